// ==== ctrl_settings.svh ====
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// register file sizes
`define NUM_LREG 32
`define NUM_PREG 64

// index widths
`define LREG_W 5
`define PREG_W 6

// reorder buffer
`define ROB_DEPTH 16
`define ROB_IDX_W 4

`define PC_W 64

`endif

// ==== ctrl_pkg.sv ====
`include "ctrl_settings.svh"

package ctrl_pkg;

    typedef logic [`LREG_W-1:0] lreg_t;
    typedef logic [`PREG_W-1:0] preg_t;

    // msb is the wrap flag, low bits select the slot
    typedef logic [`ROB_IDX_W:0] rob_idx_t;

    typedef logic [`PC_W-1:0] pc_t;

    typedef enum logic [1:0] {
        entry_empty,
        entry_waiting,
        entry_done
    } rob_entry_state_t;

endpackage

// ==== rename_table.sv ====
`timescale 1ns/1ps
`include "ctrl_settings.svh"

module rename_table (
    input  logic            clock,
    input  logic            reset_n,
    input  ctrl_pkg::lreg_t rd_addr1,
    input  ctrl_pkg::lreg_t rd_addr2,
    input  ctrl_pkg::lreg_t rd_addr3,
    output ctrl_pkg::preg_t rd_data1,
    output ctrl_pkg::preg_t rd_data2,
    output ctrl_pkg::preg_t rd_data3,
    input  logic            wr_en,
    input  ctrl_pkg::lreg_t wr_addr,
    input  ctrl_pkg::preg_t wr_data
);
    import ctrl_pkg::*;

    preg_t map [`NUM_LREG];

    // identity map out of reset, x0 stays on p0
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_LREG; i++) begin
                map[i] <= preg_t'(i);
            end
        end else if (wr_en) begin
            map[wr_addr] <= wr_data;
        end
    end

    // sources
    assign rd_data1 = map[rd_addr1];
    assign rd_data2 = map[rd_addr2];

    // old mapping of the destination
    assign rd_data3 = map[rd_addr3];

endmodule

// ==== free_list.sv ====
`timescale 1ns/1ps
`include "ctrl_settings.svh"

module free_list (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            alloc,
    output ctrl_pkg::preg_t alloc_preg,
    output logic            has_free,
    input  logic            release_en,
    input  ctrl_pkg::preg_t release_preg
);
    import ctrl_pkg::*;

    localparam int FL_DEPTH = `NUM_PREG - `NUM_LREG;
    localparam int FL_PTR_W = $clog2(FL_DEPTH);

    preg_t               slots [FL_DEPTH];
    logic [FL_PTR_W-1:0] head;
    logic [FL_PTR_W-1:0] tail;
    logic [FL_PTR_W:0]   count;

    // queue starts full with the registers above the logical ones
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                slots[i] <= preg_t'(`NUM_LREG + i);
            end
        end else if (release_en) begin
            slots[tail] <= release_preg;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (alloc) begin
                head <= head + 1'b1;
            end
            if (release_en) begin
                tail <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= (FL_PTR_W + 1)'(FL_DEPTH);
        end else begin
            case ({release_en, alloc})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign has_free   = (count != '0);
    assign alloc_preg = slots[head];

endmodule

// ==== busy_table.sv ====
`timescale 1ns/1ps
`include "ctrl_settings.svh"

module busy_table (
    input  logic            clock,
    input  logic            reset_n,
    input  ctrl_pkg::preg_t read_preg1,
    input  ctrl_pkg::preg_t read_preg2,
    output logic            busy1,
    output logic            busy2,
    input  logic            set_en,
    input  ctrl_pkg::preg_t set_preg,
    input  logic            clear_en,
    input  ctrl_pkg::preg_t clear_preg
);

    logic [`NUM_PREG-1:0] busy;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else begin
            if (clear_en) begin
                busy[clear_preg] <= 1'b0;
            end
            // a new producer takes the register over
            if (set_en) begin
                busy[set_preg] <= 1'b1;
            end
        end
    end

    // p0 is the zero register, never pending
    assign busy1 = (read_preg1 != '0) && busy[read_preg1];
    assign busy2 = (read_preg2 != '0) && busy[read_preg2];

endmodule

// ==== rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage (
    input  logic            clock,
    input  logic            reset_n,
    // decoded instruction in
    input  logic            in_valid,
    output logic            in_ready,
    input  ctrl_pkg::lreg_t in_lrs1,
    input  ctrl_pkg::lreg_t in_lrs2,
    input  ctrl_pkg::lreg_t in_lrd,
    input  logic            in_need_to_wb,
    input  ctrl_pkg::pc_t   in_pc,
    // renamed instruction out
    output logic            issue_valid,
    input  logic            issue_ready,
    output ctrl_pkg::preg_t issue_prs1,
    output ctrl_pkg::preg_t issue_prs2,
    output ctrl_pkg::preg_t issue_prd,
    output ctrl_pkg::preg_t issue_old_prd,
    output logic            issue_need_to_wb,
    output ctrl_pkg::lreg_t issue_lrd,
    output ctrl_pkg::pc_t   issue_pc,
    // map table
    output ctrl_pkg::lreg_t rat_rd_addr1,
    output ctrl_pkg::lreg_t rat_rd_addr2,
    output ctrl_pkg::lreg_t rat_rd_addr3,
    input  ctrl_pkg::preg_t rat_rd_data1,
    input  ctrl_pkg::preg_t rat_rd_data2,
    input  ctrl_pkg::preg_t rat_rd_data3,
    output logic            rat_wr_en,
    output ctrl_pkg::lreg_t rat_wr_addr,
    output ctrl_pkg::preg_t rat_wr_data,
    // free list and rob room
    output logic            alloc,
    input  ctrl_pkg::preg_t alloc_preg,
    input  logic            has_free,
    input  logic            has_room
);

    logic running;
    logic do_alloc;
    logic in_fire;

    // holds in_ready low until the first edge after reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign in_ready = running && has_free && has_room && (!issue_valid || issue_ready);
    assign in_fire  = in_valid && in_ready;

    // x0 writes are dropped, no register is spent on them
    assign do_alloc = in_need_to_wb && (in_lrd != '0);

    assign rat_rd_addr1 = in_lrs1;
    assign rat_rd_addr2 = in_lrs2;
    assign rat_rd_addr3 = in_lrd;

    assign alloc       = in_fire && do_alloc;
    assign rat_wr_en   = alloc;
    assign rat_wr_addr = in_lrd;
    assign rat_wr_data = alloc_preg;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            issue_valid <= 1'b0;
        end else if (in_fire) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    // payload only moves on an accepted instruction
    always_ff @(posedge clock) begin
        if (in_fire) begin
            issue_prs1       <= rat_rd_data1;
            issue_prs2       <= rat_rd_data2;
            issue_prd        <= do_alloc ? alloc_preg : '0;
            issue_old_prd    <= rat_rd_data3;
            issue_need_to_wb <= do_alloc;
            issue_lrd        <= in_lrd;
            issue_pc         <= in_pc;
        end
    end

endmodule

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps
`include "ctrl_settings.svh"

module reorder_buffer (
    input  logic               clock,
    input  logic               reset_n,
    // dispatch
    input  logic               enq_valid,
    input  ctrl_pkg::lreg_t    enq_lrd,
    input  ctrl_pkg::preg_t    enq_prd,
    input  ctrl_pkg::preg_t    enq_old_prd,
    input  logic               enq_need_to_wb,
    input  ctrl_pkg::pc_t      enq_pc,
    output ctrl_pkg::rob_idx_t enq_robidx,
    output logic               has_room,
    // writeback
    input  logic               wb_valid,
    input  ctrl_pkg::rob_idx_t wb_robidx,
    // retirement
    output logic               commit_valid,
    output ctrl_pkg::lreg_t    commit_lrd,
    output ctrl_pkg::preg_t    commit_prd,
    output ctrl_pkg::preg_t    commit_old_prd,
    output ctrl_pkg::pc_t      commit_pc,
    output logic               commit_need_to_wb
);
    import ctrl_pkg::*;

    rob_entry_state_t state      [`ROB_DEPTH];
    lreg_t            lrd_q      [`ROB_DEPTH];
    preg_t            prd_q      [`ROB_DEPTH];
    preg_t            old_prd_q  [`ROB_DEPTH];
    logic             need_wb_q  [`ROB_DEPTH];
    pc_t              pc_q       [`ROB_DEPTH];

    rob_idx_t               head;
    rob_idx_t               tail;
    rob_idx_t               count;
    logic [`ROB_IDX_W-1:0]  head_slot;
    logic [`ROB_IDX_W-1:0]  tail_slot;
    logic [`ROB_IDX_W-1:0]  wb_slot;

    assign head_slot = head[`ROB_IDX_W-1:0];
    assign tail_slot = tail[`ROB_IDX_W-1:0];
    assign wb_slot   = wb_robidx[`ROB_IDX_W-1:0];

    // wrap flag makes the difference exact up to a full queue
    assign count = tail - head;

    // one slot kept back for the instruction sitting in rename
    assign has_room   = (count <= rob_idx_t'(`ROB_DEPTH - 2));
    assign enq_robidx = tail;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= entry_empty;
            end
        end else begin
            if (wb_valid) begin
                state[wb_slot] <= entry_done;
            end
            if (commit_valid) begin
                state[head_slot] <= entry_empty;
            end
            if (enq_valid) begin
                state[tail_slot] <= entry_waiting;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            if (enq_valid) begin
                tail <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq_valid) begin
            lrd_q[tail_slot]     <= enq_lrd;
            prd_q[tail_slot]     <= enq_prd;
            old_prd_q[tail_slot] <= enq_old_prd;
            need_wb_q[tail_slot] <= enq_need_to_wb;
            pc_q[tail_slot]      <= enq_pc;
        end
    end

    // an empty queue has an empty head entry, so no false retire
    assign commit_valid      = (state[head_slot] == entry_done);
    assign commit_lrd        = lrd_q[head_slot];
    assign commit_prd        = prd_q[head_slot];
    assign commit_old_prd    = old_prd_q[head_slot];
    assign commit_need_to_wb = need_wb_q[head_slot];
    assign commit_pc         = pc_q[head_slot];

endmodule

// ==== ctrl_block.sv ====
`timescale 1ns/1ps

module ctrl_block (
    input  logic               clock,
    input  logic               reset_n,
    // rename input
    input  logic               in_valid,
    output logic               in_ready,
    input  ctrl_pkg::lreg_t    in_lrs1,
    input  ctrl_pkg::lreg_t    in_lrs2,
    input  ctrl_pkg::lreg_t    in_lrd,
    input  logic               in_need_to_wb,
    input  ctrl_pkg::pc_t      in_pc,
    // issue output
    output logic               issue_valid,
    input  logic               issue_ready,
    output ctrl_pkg::preg_t    issue_prs1,
    output ctrl_pkg::preg_t    issue_prs2,
    output ctrl_pkg::preg_t    issue_prd,
    output ctrl_pkg::preg_t    issue_old_prd,
    output logic               issue_need_to_wb,
    output ctrl_pkg::rob_idx_t issue_robidx,
    output logic               issue_src1_busy,
    output logic               issue_src2_busy,
    // writeback
    input  logic               wb_valid,
    input  ctrl_pkg::rob_idx_t wb_robidx,
    input  ctrl_pkg::preg_t    wb_prd,
    input  logic               wb_need_to_wb,
    // retirement
    output logic               commit_valid,
    output ctrl_pkg::lreg_t    commit_lrd,
    output ctrl_pkg::preg_t    commit_prd,
    output ctrl_pkg::preg_t    commit_old_prd,
    output ctrl_pkg::pc_t      commit_pc
);
    import ctrl_pkg::*;

    lreg_t rat_rd_addr1;
    lreg_t rat_rd_addr2;
    lreg_t rat_rd_addr3;
    preg_t rat_rd_data1;
    preg_t rat_rd_data2;
    preg_t rat_rd_data3;
    logic  rat_wr_en;
    lreg_t rat_wr_addr;
    preg_t rat_wr_data;

    logic  alloc;
    preg_t alloc_preg;
    logic  has_free;
    logic  has_room;

    lreg_t issue_lrd;
    pc_t   issue_pc;
    logic  dispatch_fire;
    logic  busy_set_en;
    logic  busy_clear_en;
    logic  commit_need_to_wb;
    logic  release_en;

    assign dispatch_fire = issue_valid && issue_ready;
    assign busy_set_en   = dispatch_fire && issue_need_to_wb;
    assign busy_clear_en = wb_valid && wb_need_to_wb;
    assign release_en    = commit_valid && commit_need_to_wb;

    rename_table u_rename_table (
        .clock   (clock),
        .reset_n (reset_n),
        .rd_addr1(rat_rd_addr1),
        .rd_addr2(rat_rd_addr2),
        .rd_addr3(rat_rd_addr3),
        .rd_data1(rat_rd_data1),
        .rd_data2(rat_rd_data2),
        .rd_data3(rat_rd_data3),
        .wr_en   (rat_wr_en),
        .wr_addr (rat_wr_addr),
        .wr_data (rat_wr_data)
    );

    // retirement hands the displaced register back
    free_list u_free_list (
        .clock       (clock),
        .reset_n     (reset_n),
        .alloc       (alloc),
        .alloc_preg  (alloc_preg),
        .has_free    (has_free),
        .release_en  (release_en),
        .release_preg(commit_old_prd)
    );

    rename_stage u_rename_stage (
        .clock           (clock),
        .reset_n         (reset_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_lrs1         (in_lrs1),
        .in_lrs2         (in_lrs2),
        .in_lrd          (in_lrd),
        .in_need_to_wb   (in_need_to_wb),
        .in_pc           (in_pc),
        .issue_valid     (issue_valid),
        .issue_ready     (issue_ready),
        .issue_prs1      (issue_prs1),
        .issue_prs2      (issue_prs2),
        .issue_prd       (issue_prd),
        .issue_old_prd   (issue_old_prd),
        .issue_need_to_wb(issue_need_to_wb),
        .issue_lrd       (issue_lrd),
        .issue_pc        (issue_pc),
        .rat_rd_addr1    (rat_rd_addr1),
        .rat_rd_addr2    (rat_rd_addr2),
        .rat_rd_addr3    (rat_rd_addr3),
        .rat_rd_data1    (rat_rd_data1),
        .rat_rd_data2    (rat_rd_data2),
        .rat_rd_data3    (rat_rd_data3),
        .rat_wr_en       (rat_wr_en),
        .rat_wr_addr     (rat_wr_addr),
        .rat_wr_data     (rat_wr_data),
        .alloc           (alloc),
        .alloc_preg      (alloc_preg),
        .has_free        (has_free),
        .has_room        (has_room)
    );

    // source busy bits looked up with the registered sources
    busy_table u_busy_table (
        .clock     (clock),
        .reset_n   (reset_n),
        .read_preg1(issue_prs1),
        .read_preg2(issue_prs2),
        .busy1     (issue_src1_busy),
        .busy2     (issue_src2_busy),
        .set_en    (busy_set_en),
        .set_preg  (issue_prd),
        .clear_en  (busy_clear_en),
        .clear_preg(wb_prd)
    );

    reorder_buffer u_reorder_buffer (
        .clock            (clock),
        .reset_n          (reset_n),
        .enq_valid        (dispatch_fire),
        .enq_lrd          (issue_lrd),
        .enq_prd          (issue_prd),
        .enq_old_prd      (issue_old_prd),
        .enq_need_to_wb   (issue_need_to_wb),
        .enq_pc           (issue_pc),
        .enq_robidx       (issue_robidx),
        .has_room         (has_room),
        .wb_valid         (wb_valid),
        .wb_robidx        (wb_robidx),
        .commit_valid     (commit_valid),
        .commit_lrd       (commit_lrd),
        .commit_prd       (commit_prd),
        .commit_old_prd   (commit_old_prd),
        .commit_pc        (commit_pc),
        .commit_need_to_wb(commit_need_to_wb)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 8;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

// ==== ctrl_block_properties.sv ====
`timescale 1ns/1ps

module ctrl_block_properties (
    input logic               clock,
    input logic               reset_n,
    input logic               in_ready,
    input logic               has_free,
    input logic               issue_valid,
    input logic               issue_ready,
    input ctrl_pkg::preg_t    issue_prs1,
    input ctrl_pkg::preg_t    issue_prs2,
    input ctrl_pkg::preg_t    issue_prd,
    input ctrl_pkg::preg_t    issue_old_prd,
    input logic               issue_need_to_wb,
    input ctrl_pkg::rob_idx_t issue_robidx,
    input logic               commit_valid,
    input ctrl_pkg::rob_idx_t rob_count
);

    int fail_count = 0;

    // busy bits may drop when a writeback lands mid stall
    stall_hold_a: assert property (
        @(posedge clock) disable iff (!reset_n)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue_prs1)
            && $stable(issue_prs2) && $stable(issue_prd) && $stable(issue_old_prd)
            && $stable(issue_need_to_wb) && $stable(issue_robidx))
    ) else begin
        fail_count++;
        $error("issue outputs changed while the issue side was stalled");
    end

    empty_rob_a: assert property (
        @(posedge clock) disable iff (!reset_n)
        commit_valid |-> (rob_count != '0)
    ) else begin
        fail_count++;
        $error("commit_valid high while the reorder buffer is empty");
    end

    no_free_a: assert property (
        @(posedge clock) disable iff (!reset_n)
        !has_free |-> !in_ready
    ) else begin
        fail_count++;
        $error("in_ready high with no free physical register");
    end

endmodule

bind ctrl_block ctrl_block_properties u_properties (
    .clock           (clock),
    .reset_n         (reset_n),
    .in_ready        (in_ready),
    .has_free        (has_free),
    .issue_valid     (issue_valid),
    .issue_ready     (issue_ready),
    .issue_prs1      (issue_prs1),
    .issue_prs2      (issue_prs2),
    .issue_prd       (issue_prd),
    .issue_old_prd   (issue_old_prd),
    .issue_need_to_wb(issue_need_to_wb),
    .issue_robidx    (issue_robidx),
    .commit_valid    (commit_valid),
    .rob_count       (u_reorder_buffer.count)
);

// ==== ctrl_block_tb.sv ====
`timescale 1ns/1ps
`include "ctrl_settings.svh"

module ctrl_block_tb;
    import ctrl_pkg::*;

    localparam int NUM_INSTR    = 200;
    localparam int STALL_CYCLES = 40;
    localparam int RESET_CYCLES = 8;
    localparam int PERIOD_NS    = 8;

    typedef struct packed {
        preg_t    prs1;
        preg_t    prs2;
        preg_t    prd;
        preg_t    old_prd;
        logic     need_wb;
        lreg_t    lrd;
        pc_t      pc;
        rob_idx_t robidx;
    } instr_t;

    logic     clock;
    logic     reset_n;
    logic     in_valid;
    logic     in_ready;
    lreg_t    in_lrs1;
    lreg_t    in_lrs2;
    lreg_t    in_lrd;
    logic     in_need_to_wb;
    pc_t      in_pc;
    logic     issue_valid;
    logic     issue_ready;
    preg_t    issue_prs1;
    preg_t    issue_prs2;
    preg_t    issue_prd;
    preg_t    issue_old_prd;
    logic     issue_need_to_wb;
    rob_idx_t issue_robidx;
    logic     issue_src1_busy;
    logic     issue_src2_busy;
    logic     wb_valid;
    rob_idx_t wb_robidx;
    preg_t    wb_prd;
    logic     wb_need_to_wb;
    logic     commit_valid;
    lreg_t    commit_lrd;
    preg_t    commit_prd;
    preg_t    commit_old_prd;
    pc_t      commit_pc;

    // reference model state
    preg_t  model_map [`NUM_LREG];
    logic   model_busy [`NUM_PREG];
    logic   wb_done [2*`ROB_DEPTH];
    preg_t  fl_q [$];
    instr_t ren_q [$];
    instr_t rob_q [$];
    instr_t pend_wb [$];

    logic [31:0] rng_state = 32'd10;
    int          checks = 0;
    int          errors = 0;
    int          offered = 0;
    int          accepted = 0;
    int          dispatched = 0;
    int          retired = 0;
    logic        last_fire = 1'b0;
    logic        wb_enable = 1'b0;

    tb_clock_gen u_clock_gen (
        .clock  (clock),
        .reset_n(reset_n)
    );

    ctrl_block u_dut (.*);

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // sources read before the own map write
    function automatic instr_t predict_rename(lreg_t lrs1, lreg_t lrs2, lreg_t lrd,
                                              logic need_wb, pc_t pc);
        instr_t e;
        e.prs1    = model_map[lrs1];
        e.prs2    = model_map[lrs2];
        e.old_prd = model_map[lrd];
        e.need_wb = need_wb && (lrd != '0);
        e.lrd     = lrd;
        e.pc      = pc;
        e.prd     = '0;
        e.robidx  = '0;
        if (e.need_wb) begin
            checks++;
            assert (fl_q.size() > 0) else begin
                errors++;
                $display("rename accepted at %0t ns with no free register left", $time);
            end
            if (fl_q.size() > 0) begin
                e.prd = fl_q.pop_front();
                model_map[lrd] = e.prd;
            end
        end
        return e;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("error %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // a valid instruction stays put until it is taken
    task automatic offer_instr(input logic always_offer);
        if (!in_valid || last_fire) begin
            if (offered < NUM_INSTR && (always_offer || (xorshift32() % 4) != 0)) begin
                in_valid      = 1'b1;
                in_lrs1       = lreg_t'(xorshift32());
                in_lrs2       = lreg_t'(xorshift32());
                in_lrd        = lreg_t'(xorshift32());
                in_need_to_wb = (xorshift32() % 8) != 0;
                in_pc         = pc_t'(64'h8000_0000 + 4 * offered);
                offered++;
            end else begin
                in_valid = 1'b0;
            end
        end
    endtask

    // random pick among dispatched entries gives out of order writebacks
    task automatic send_writeback();
        int     pick;
        instr_t e;
        wb_valid = 1'b0;
        if (wb_enable && pend_wb.size() > 0 && (xorshift32() % 4) != 0) begin
            pick = int'(xorshift32() % pend_wb.size());
            e = pend_wb[pick];
            pend_wb.delete(pick);
            wb_valid      = 1'b1;
            wb_robidx     = e.robidx;
            wb_prd        = e.prd;
            wb_need_to_wb = e.need_wb;
        end
    endtask

    always @(posedge clock) begin : compare
        instr_t disp;
        instr_t head;
        logic   do_disp;
        logic   do_commit;
        if (reset_n) begin
            do_disp   = 1'b0;
            do_commit = 1'b0;
            if (issue_valid && issue_ready) begin
                checks++;
                assert (ren_q.size() > 0) else begin
                    errors++;
                    $display("dispatch at %0t ns without an accepted instruction", $time);
                end
                if (ren_q.size() > 0) begin
                    disp = ren_q.pop_front();
                    disp.robidx = rob_idx_t'(dispatched);
                    do_disp = 1'b1;
                    check_value("issue_prs1", issue_prs1, disp.prs1);
                    check_value("issue_prs2", issue_prs2, disp.prs2);
                    check_value("issue_prd", issue_prd, disp.prd);
                    check_value("issue_old_prd", issue_old_prd, disp.old_prd);
                    check_value("issue_need_to_wb", issue_need_to_wb, disp.need_wb);
                    check_value("issue_robidx", issue_robidx, disp.robidx);
                    check_value("issue_src1_busy", issue_src1_busy, model_busy[disp.prs1]);
                    check_value("issue_src2_busy", issue_src2_busy, model_busy[disp.prs2]);
                end
            end
            if (commit_valid) begin
                checks++;
                assert (rob_q.size() > 0) else begin
                    errors++;
                    $display("retirement at %0t ns with nothing dispatched", $time);
                end
                if (rob_q.size() > 0) begin
                    head = rob_q[0];
                    do_commit = 1'b1;
                    checks++;
                    assert (wb_done[head.robidx]) else begin
                        errors++;
                        $display("rob entry %0d retired at %0t ns before its writeback",
                                 head.robidx, $time);
                    end
                    check_value("commit_lrd", commit_lrd, head.lrd);
                    check_value("commit_prd", commit_prd, head.prd);
                    check_value("commit_old_prd", commit_old_prd, head.old_prd);
                    check_value("commit_pc", commit_pc, head.pc);
                end
            end
            if (wb_valid) begin
                wb_done[wb_robidx] = 1'b1;
                if (wb_need_to_wb) begin
                    model_busy[wb_prd] = 1'b0;
                end
            end
            if (do_disp) begin
                if (disp.need_wb) begin
                    model_busy[disp.prd] = 1'b1;
                end
                wb_done[disp.robidx] = 1'b0;
                rob_q.push_back(disp);
                pend_wb.push_back(disp);
                dispatched++;
            end
            if (do_commit) begin
                void'(rob_q.pop_front());
                if (head.need_wb) begin
                    fl_q.push_back(head.old_prd);
                end
                retired++;
            end
            last_fire = in_valid && in_ready;
            if (last_fire) begin
                ren_q.push_back(predict_rename(in_lrs1, in_lrs2, in_lrd, in_need_to_wb, in_pc));
                accepted++;
            end
        end
    end

    initial begin : stimulus
        in_valid      = 1'b0;
        in_lrs1       = '0;
        in_lrs2       = '0;
        in_lrd        = '0;
        in_need_to_wb = 1'b0;
        in_pc         = '0;
        issue_ready   = 1'b0;
        wb_valid      = 1'b0;
        wb_robidx     = '0;
        wb_prd        = '0;
        wb_need_to_wb = 1'b0;
        for (int i = 0; i < `NUM_LREG; i++) begin
            model_map[i] = preg_t'(i);
        end
        for (int i = `NUM_LREG; i < `NUM_PREG; i++) begin
            fl_q.push_back(preg_t'(i));
        end
        for (int i = 0; i < `NUM_PREG; i++) begin
            model_busy[i] = 1'b0;
        end
        for (int i = 0; i < 2*`ROB_DEPTH; i++) begin
            wb_done[i] = 1'b0;
        end

        wait (reset_n === 1'b1);
        check_value("in_ready in reset", in_ready, 1'b0);
        check_value("issue_valid in reset", issue_valid, 1'b0);
        check_value("commit_valid in reset", commit_valid, 1'b0);
        @(negedge clock);
        check_value("in_ready after reset", in_ready, 1'b1);

        // writebacks held off until the rob fills up
        issue_ready = 1'b1;
        repeat (STALL_CYCLES) begin
            offer_instr(1'b1);
            send_writeback();
            @(negedge clock);
        end
        check_value("accepted with writeback held", accepted, `ROB_DEPTH);
        check_value("dispatched with writeback held", dispatched, `ROB_DEPTH);
        check_value("in_ready with full rob", in_ready, 1'b0);

        wb_enable = 1'b1;
        while (retired < NUM_INSTR) begin
            issue_ready = (xorshift32() % 4) != 0;
            offer_instr(1'b0);
            send_writeback();
            @(negedge clock);
        end
        in_valid = 1'b0;
        wb_valid = 1'b0;
        repeat (4) @(negedge clock);

        check_value("issue_valid when drained", issue_valid, 1'b0);
        check_value("commit_valid when drained", commit_valid, 1'b0);
        check_value("in_ready when drained", in_ready, 1'b1);
        errors += u_dut.u_properties.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        #((NUM_INSTR * 40 + RESET_CYCLES) * PERIOD_NS);
        $display("timeout: %0d of %0d instructions retired", retired, NUM_INSTR);
        $display("checks %0d, errors %0d", checks, errors + u_dut.u_properties.fail_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
ctrl_pkg.sv
rename_table.sv
free_list.sv
busy_table.sv
rename_stage.sv
reorder_buffer.sv
ctrl_block.sv
tb_clock_gen.sv
ctrl_block_properties.sv
ctrl_block_tb.sv
